/* ooo_issue.f */
+incdir+hdl
hdl/ooo_pkg.sv
hdl/rob_tracker.sv
hdl/dispatch_unit.sv
hdl/reservation_station.sv
hdl/exec_unit.sv
hdl/ooo_issue_top.sv
bench/ooo_issue_assert.sv
bench/ooo_issue_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ooo_issue_tb
FILELIST  = ooo_issue.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/ooo_issue_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module ooo_issue_tb;

    localparam int NUM_INDEP   = 16;
    localparam int NUM_CHAIN   = 6;
    localparam int NUM_RANDOM  = 120;
    localparam int NUM_PRE_FL  = 6;
    localparam int NUM_POST_FL = 24;
    localparam int NUM_INSTR   = NUM_INDEP + NUM_CHAIN + NUM_RANDOM + NUM_PRE_FL + NUM_POST_FL;
    localparam int TIMEOUT     = NUM_INSTR * 12 + 100;

    logic              clk;
    logic              rst;
    logic              issue_valid;
    ooo_pkg::op_e      issue_op;
    logic [2:0]        issue_funct3;
    logic [6:0]        issue_funct7;
    logic [`XLEN-1:0]  issue_pc;
    logic              src1_valid;
    logic [`TAG_W-1:0] src1_tag;
    logic [`XLEN-1:0]  src1_data;
    logic              src2_valid;
    logic [`TAG_W-1:0] src2_tag;
    logic [`XLEN-1:0]  src2_data;
    logic              flush;
    logic              issue_stall;
    logic [`TAG_W-1:0] issue_tag;
    logic              commit_valid;
    logic [`TAG_W-1:0] commit_tag;
    logic [`XLEN-1:0]  commit_data;
    logic              commit_br;
    logic              jalr_valid;
    logic [`XLEN-1:0]  jalr_target;

    logic [31:0]       seed = 32'd41775;
    int                errors = 0;
    int                cycles = 0;
    int                accepts = 0;
    int                commits = 0;
    int                dropped = 0;
    int                stall_cycles = 0;
    logic [`TAG_W-1:0] next_tag = '0;
    logic [`TAG_W-1:0] exp_tag [$]; // Live tags in issue order.
    logic [`XLEN-1:0]  exp_data [$];
    logic              exp_br [$];
    logic              exp_jalr [$];
    logic [`XLEN-1:0]  exp_target [$];

    ooo_issue_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    // Expected write-back value per RV32I rules.
    function automatic logic [31:0] ref_result(ooo_pkg::op_e op, logic [2:0] f3, logic [6:0] f7,
                                               logic [31:0] a, logic [31:0] b, logic [31:0] pc);
        logic [31:0] r;
        logic [4:0]  sh;
        r  = '0;
        sh = b[4:0];
        case (op)
            ooo_pkg::JAL, ooo_pkg::JALR: r = pc + 32'd4;
            ooo_pkg::AUIPC:              r = pc + b;
            ooo_pkg::LUI:                r = b;
            ooo_pkg::BRANCH: begin
                case (f3)
                    3'b000:  r[0] = (a == b);
                    3'b001:  r[0] = (a != b);
                    3'b100:  r[0] = $signed(a) < $signed(b);
                    3'b101:  r[0] = $signed(a) >= $signed(b);
                    3'b110:  r[0] = a < b;
                    3'b111:  r[0] = a >= b;
                    default: r[0] = 1'b0;
                endcase
            end
            default: begin
                case (f3)
                    3'b000:  r = (op == ooo_pkg::OP_REG && f7[5]) ? a - b : a + b;
                    3'b001:  r = a << sh;
                    3'b010:  r[0] = $signed(a) < $signed(b);
                    3'b011:  r[0] = a < b;
                    3'b100:  r = a ^ b;
                    3'b101: begin
                        if (f7[5]) begin
                            r = $signed(a) >>> sh;
                        end else begin
                            r = a >> sh;
                        end
                    end
                    3'b110:  r = a | b;
                    default: r = a & b;
                endcase
            end
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic pick_random(output ooo_pkg::op_e op, output logic [2:0] f3,
                               output logic [6:0] f7, output logic [31:0] pc,
                               output logic [31:0] a, output logic [31:0] b);
        logic [31:0] r;
        r  = next_rand();
        f3 = r[10:8];
        f7 = r[11] ? 7'h20 : 7'h00;
        pc = {14'd0, r[31:16], 2'b00};
        a  = next_rand();
        b  = r[12] ? a : next_rand(); // Equal operands now and then for branches.
        case (r[2:0])
            3'd0, 3'd1, 3'd2: op = ooo_pkg::OP_REG;
            3'd3: op = ooo_pkg::OP_IMM;
            3'd4: begin
                op = ooo_pkg::BRANCH;
                if (f3[2:1] == 2'b01) begin
                    f3 = 3'b000;
                end
            end
            3'd5: op = r[13] ? ooo_pkg::JALR : ooo_pkg::JAL;
            3'd6: op = ooo_pkg::AUIPC;
            default: begin
                op = ooo_pkg::LUI;
                b  = {b[31:12], 12'd0};
            end
        endcase
    endtask

    // Mode 0 independent, 1 random producers, 2 source 1 on the newest tag.
    task automatic send(input ooo_pkg::op_e op, input logic [2:0] f3, input logic [6:0] f7,
                        input logic [31:0] pc, input logic [31:0] a, input logic [31:0] b,
                        input int dep_mode);
        logic [31:0] av;
        logic [31:0] bv;
        logic [31:0] r1;
        logic [31:0] r2;
        int          n;
        int          idx;
        @(negedge clk);
        issue_valid = 1'b0;
        while (issue_stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        n  = exp_tag.size();
        r1 = next_rand();
        r2 = next_rand();
        av = a;
        bv = b;
        src1_valid = 1'b1;
        src1_tag   = '0;
        src1_data  = a;
        src2_valid = 1'b1;
        src2_tag   = '0;
        src2_data  = b;
        if (n > 0 && (dep_mode == 2 || (dep_mode == 1 && r1[1:0] == 2'b00))) begin
            idx        = (dep_mode == 2) ? n - 1 : int'(r1[31:8]) % n;
            src1_valid = 1'b0;
            src1_tag   = exp_tag[idx];
            src1_data  = 32'hbad0_0001;
            av         = exp_data[idx];
        end
        if (n > 0 && dep_mode == 1 && r2[1:0] == 2'b00 &&
            (op == ooo_pkg::OP_REG || op == ooo_pkg::BRANCH)) begin
            idx        = int'(r2[31:8]) % n;
            src2_valid = 1'b0;
            src2_tag   = exp_tag[idx];
            src2_data  = 32'hbad0_0002;
            bv         = exp_data[idx];
        end
        check_value("issue_tag", 32'(issue_tag), 32'(next_tag));
        exp_tag.push_back(next_tag);
        exp_data.push_back(ref_result(op, f3, f7, av, bv, pc));
        exp_br.push_back(op == ooo_pkg::BRANCH);
        exp_jalr.push_back(op == ooo_pkg::JALR);
        exp_target.push_back((av + bv) & 32'hffff_fffe);
        issue_op     = op;
        issue_funct3 = f3;
        issue_funct7 = f7;
        issue_pc     = pc;
        issue_valid  = 1'b1;
        next_tag     = next_tag + 1'b1;
        accepts++;
    endtask

    task automatic send_random(input int count, input int dep_mode);
        ooo_pkg::op_e op;
        logic [2:0]   f3;
        logic [6:0]   f7;
        logic [31:0]  pc;
        logic [31:0]  a;
        logic [31:0]  b;
        for (int i = 0; i < count; i++) begin
            pick_random(op, f3, f7, pc, a, b);
            send(op, f3, f7, pc, a, b, dep_mode);
        end
    endtask

    task automatic flush_all();
        @(negedge clk);
        issue_valid = 1'b0;
        flush       = 1'b1;
        dropped     = dropped + exp_tag.size();
        exp_tag.delete();
        exp_data.delete();
        exp_br.delete();
        exp_jalr.delete();
        exp_target.delete();
        next_tag = '0; // Tracker restarts at tag 0.
        @(negedge clk);
        flush = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // Compare each commit against the oldest expected entry.
    always @(posedge clk) begin
        if (!rst && !flush && commit_valid) begin
            if (exp_tag.size() == 0) begin
                $display("Unexpected commit of tag %0d at %0t", commit_tag, $time);
                errors++;
            end else begin
                check_value("commit_tag", 32'(commit_tag), 32'(exp_tag[0]));
                check_value("commit_data", commit_data, exp_data[0]);
                check_value("commit_br", 32'(commit_br), 32'(exp_br[0]));
                check_value("jalr_valid", 32'(jalr_valid), 32'(exp_jalr[0]));
                if (exp_jalr[0]) begin
                    check_value("jalr_target", jalr_target, exp_target[0]);
                end
                void'(exp_tag.pop_front());
                void'(exp_data.pop_front());
                void'(exp_br.pop_front());
                void'(exp_jalr.pop_front());
                void'(exp_target.pop_front());
                commits++;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d commits outstanding",
                     cycles, exp_tag.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = ooo_pkg::OP_REG;
        issue_funct3 = '0;
        issue_funct7 = '0;
        issue_pc     = '0;
        src1_valid   = 1'b1;
        src1_tag     = '0;
        src1_data    = '0;
        src2_valid   = 1'b1;
        src2_tag     = '0;
        src2_data    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int f = 0; f < 2; f++) begin
            for (int i = 0; i < 8; i++) begin
                send(ooo_pkg::OP_REG, 3'(i), (f == 1) ? 7'h20 : 7'h00, 32'h100 + 32'(4 * i),
                     next_rand(), next_rand(), 0);
            end
        end
        for (int i = 0; i < NUM_CHAIN; i++) begin
            send(ooo_pkg::OP_IMM, 3'b000, 7'h00, 32'h200, 32'd0, 32'(i + 1), 2);
        end
        send_random(NUM_RANDOM, 1);
        send_random(NUM_PRE_FL, 1);
        flush_all();
        send_random(NUM_POST_FL, 1);
        @(negedge clk);
        issue_valid = 1'b0;
        while (exp_tag.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        check_value("commit_count", 32'(commits), 32'(accepts - dropped));
        if (stall_cycles == 0) begin
            $display("The issue stall was never raised");
            errors++;
        end
        $display("Errors %0d, accepted %0d, committed %0d, flushed %0d, stall cycles %0d",
                 errors, accepts, commits, dropped, stall_cycles);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/ooo_issue_assert.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module ooo_issue_assert (
    input logic               clk,
    input logic               rst,
    input logic               flush,
    input logic [`NUM_RS-1:0] rs_empty,
    input logic [`NUM_RS-1:0] load_word,
    input logic [`NUM_RS-1:0] wr_valid,
    input logic               commit_valid,
    input logic               jalr_valid
);

    // A station leaves EMPTY on load and is back in EMPTY when its result appears.
    for (genvar i = 0; i < `NUM_RS; i++) begin : g_rs
        a_load_busy: assert property (@(posedge clk) disable iff (rst)
            load_word[i] |=> !rs_empty[i]) else $error("Loaded station stayed empty.");
        a_wr_start: assert property (@(posedge clk) disable iff (rst)
            wr_valid[i] |-> (rs_empty[i] && !$past(rs_empty[i])))
            else $error("Result not one cycle after its station started.");
    end

    a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
        flush |=> !commit_valid) else $error("Commit in the cycle after a flush.");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!commit_valid && !jalr_valid && wr_valid == '0 && load_word == '0))
        else $error("Outputs active during reset.");

endmodule

bind ooo_issue_top ooo_issue_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .rs_empty     (rs_empty),
    .load_word    (load_word),
    .wr_valid     (wr_valid),
    .commit_valid (commit_valid),
    .jalr_valid   (jalr_valid)
);

`default_nettype wire

/* hdl/ooo_issue_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module ooo_issue_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ooo_pkg::op_e      issue_op,
    input  logic [2:0]        issue_funct3,
    input  logic [6:0]        issue_funct7,
    input  logic [`XLEN-1:0]  issue_pc,
    input  logic              src1_valid,
    input  logic [`TAG_W-1:0] src1_tag,
    input  logic [`XLEN-1:0]  src1_data,
    input  logic              src2_valid,
    input  logic [`TAG_W-1:0] src2_tag,
    input  logic [`XLEN-1:0]  src2_data,
    input  logic              flush,
    output logic              issue_stall,
    output logic [`TAG_W-1:0] issue_tag,
    output logic              commit_valid,
    output logic [`TAG_W-1:0] commit_tag,
    output logic [`XLEN-1:0]  commit_data,
    output logic              commit_br,
    output logic              jalr_valid,
    output logic [`XLEN-1:0]  jalr_target
);

    logic                 alloc;
    logic                 tags_full;
    logic [`NUM_TAGS-1:0] allocated;
    logic [`NUM_TAGS-1:0] calculated;
    logic [`XLEN-1:0]     tag_data [`NUM_TAGS];
    logic [`NUM_RS-1:0]   rs_empty;
    logic [`NUM_RS-1:0]   load_word;
    ooo_pkg::op_e         rs_op [`NUM_RS];
    logic [2:0]           rs_funct3 [`NUM_RS];
    logic [6:0]           rs_funct7 [`NUM_RS];
    logic [`XLEN-1:0]     rs_pc [`NUM_RS];
    logic [`TAG_W-1:0]    rs_rd_tag [`NUM_RS];
    logic [`NUM_RS-1:0]   rs_src1_valid;
    logic [`TAG_W-1:0]    rs_src1_tag [`NUM_RS];
    logic [`XLEN-1:0]     rs_src1_data [`NUM_RS];
    logic [`NUM_RS-1:0]   rs_src2_valid;
    logic [`TAG_W-1:0]    rs_src2_tag [`NUM_RS];
    logic [`XLEN-1:0]     rs_src2_data [`NUM_RS];
    logic [`NUM_RS-1:0]   wr_valid;
    logic [`TAG_W-1:0]    wr_tag [`NUM_RS];
    logic [`XLEN-1:0]     wr_data [`NUM_RS];
    logic [`NUM_RS-1:0]   wr_br;
    logic [`NUM_RS-1:0]   wr_jalr;
    logic [`XLEN-1:0]     wr_jalr_target [`NUM_RS];

    rob_tracker u_rob_tracker (
        .alloc_tag (issue_tag),
        .*
    );

    dispatch_unit u_dispatch_unit (
        .alloc_tag (issue_tag),
        .*
    );

    for (genvar i = 0; i < `NUM_RS; i++) begin : g_rs
        logic              start_exe;
        ooo_pkg::op_e      ex_op;
        logic [2:0]        ex_funct3;
        logic [6:0]        ex_funct7;
        logic [`TAG_W-1:0] ex_rd_tag;
        logic [`XLEN-1:0]  ex_pc;
        logic [`XLEN-1:0]  ex_src1_data;
        logic [`XLEN-1:0]  ex_src2_data;
        logic              jalr_executed;
        logic              ld_pc_to_cdb;
        logic              update_br;

        reservation_station u_rs (
            .load_word      (load_word[i]),
            .res_op         (rs_op[i]),
            .res_funct3     (rs_funct3[i]),
            .res_funct7     (rs_funct7[i]),
            .res_pc         (rs_pc[i]),
            .res_rd_tag     (rs_rd_tag[i]),
            .res_src1_valid (rs_src1_valid[i]),
            .res_src1_tag   (rs_src1_tag[i]),
            .res_src1_data  (rs_src1_data[i]),
            .res_src2_valid (rs_src2_valid[i]),
            .res_src2_tag   (rs_src2_tag[i]),
            .res_src2_data  (rs_src2_data[i]),
            .res_empty      (rs_empty[i]),
            .*
        );

        exec_unit u_exec (
            .wr_valid       (wr_valid[i]),
            .wr_tag         (wr_tag[i]),
            .wr_data        (wr_data[i]),
            .wr_br          (wr_br[i]),
            .wr_jalr        (wr_jalr[i]),
            .wr_jalr_target (wr_jalr_target[i]),
            .*
        );
    end

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module exec_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_exe,
    input  ooo_pkg::op_e      ex_op,
    input  logic [2:0]        ex_funct3,
    input  logic [6:0]        ex_funct7,
    input  logic [`TAG_W-1:0] ex_rd_tag,
    input  logic [`XLEN-1:0]  ex_pc,
    input  logic [`XLEN-1:0]  ex_src1_data,
    input  logic [`XLEN-1:0]  ex_src2_data,
    input  logic              ld_pc_to_cdb,
    input  logic              update_br,
    input  logic              jalr_executed,
    output logic              wr_valid,
    output logic [`TAG_W-1:0] wr_tag,
    output logic [`XLEN-1:0]  wr_data,
    output logic              wr_br,
    output logic              wr_jalr,
    output logic [`XLEN-1:0]  wr_jalr_target
);

    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] pc_out;
    logic [`XLEN-1:0] jalr_sum;
    logic [4:0]       shamt;
    logic             taken;

    assign shamt    = ex_src2_data[4:0];
    assign jalr_sum = ex_src1_data + ex_src2_data;

    always_comb begin : alu
        alu_out = '0;
        case (ex_funct3)
            3'b000: begin
                if (ex_op == ooo_pkg::OP_REG && ex_funct7[5]) begin
                    alu_out = ex_src1_data - ex_src2_data;
                end else begin
                    alu_out = ex_src1_data + ex_src2_data;
                end
            end
            3'b001: alu_out = ex_src1_data << shamt;
            3'b010: alu_out[0] = $signed(ex_src1_data) < $signed(ex_src2_data);
            3'b011: alu_out[0] = ex_src1_data < ex_src2_data;
            3'b100: alu_out = ex_src1_data ^ ex_src2_data;
            3'b101: begin
                if (ex_funct7[5]) begin
                    alu_out = $signed(ex_src1_data) >>> shamt; // sra
                end else begin
                    alu_out = ex_src1_data >> shamt;
                end
            end
            3'b110: alu_out = ex_src1_data | ex_src2_data;
            default: alu_out = ex_src1_data & ex_src2_data;
        endcase
    end

    always_comb begin : branch_compare
        case (ex_funct3)
            3'b000:  taken = ex_src1_data == ex_src2_data;
            3'b001:  taken = ex_src1_data != ex_src2_data;
            3'b100:  taken = $signed(ex_src1_data) < $signed(ex_src2_data);
            3'b101:  taken = $signed(ex_src1_data) >= $signed(ex_src2_data);
            3'b110:  taken = ex_src1_data < ex_src2_data;
            3'b111:  taken = ex_src1_data >= ex_src2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin : pc_result
        pc_out = '0;
        case (ex_op)
            ooo_pkg::AUIPC:  pc_out = ex_pc + ex_src2_data;
            ooo_pkg::LUI:    pc_out = ex_src2_data;
            ooo_pkg::BRANCH: pc_out[0] = taken;
            default:         pc_out = ex_pc + 3'd4; // Link address.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= start_exe;
        end
    end

    always_ff @(posedge clk) begin
        if (start_exe) begin
            wr_tag         <= ex_rd_tag;
            wr_data        <= ld_pc_to_cdb ? pc_out : alu_out;
            wr_br          <= update_br;
            wr_jalr        <= jalr_executed;
            wr_jalr_target <= {jalr_sum[`XLEN-1:1], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* hdl/reservation_station.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module reservation_station (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_word,
    input  ooo_pkg::op_e         res_op,
    input  logic [2:0]           res_funct3,
    input  logic [6:0]           res_funct7,
    input  logic [`XLEN-1:0]     res_pc,
    input  logic [`TAG_W-1:0]    res_rd_tag,
    input  logic                 res_src1_valid,
    input  logic [`TAG_W-1:0]    res_src1_tag,
    input  logic [`XLEN-1:0]     res_src1_data,
    input  logic                 res_src2_valid,
    input  logic [`TAG_W-1:0]    res_src2_tag,
    input  logic [`XLEN-1:0]     res_src2_data,
    input  logic [`NUM_TAGS-1:0] allocated,
    input  logic [`NUM_TAGS-1:0] calculated,
    input  logic [`XLEN-1:0]     tag_data [`NUM_TAGS],
    output logic                 res_empty,
    output logic                 start_exe,
    output ooo_pkg::op_e         ex_op,
    output logic [2:0]           ex_funct3,
    output logic [6:0]           ex_funct7,
    output logic [`TAG_W-1:0]    ex_rd_tag,
    output logic [`XLEN-1:0]     ex_pc,
    output logic [`XLEN-1:0]     ex_src1_data,
    output logic [`XLEN-1:0]     ex_src2_data,
    output logic                 jalr_executed,
    output logic                 ld_pc_to_cdb,
    output logic                 update_br
);

    ooo_pkg::rs_state_e state;
    ooo_pkg::rs_state_e next_state;

    logic             src1_valid; // Operands captured while waiting.
    logic [`XLEN-1:0] src1_data;
    logic             src2_valid;
    logic [`XLEN-1:0] src2_data;
    logic             have1;
    logic             have2;
    logic [`XLEN-1:0] have1_data;
    logic [`XLEN-1:0] have2_data;
    logic             peek;
    logic             src1_rdy;
    logic             src2_rdy;
    logic             live;       // Low once a flush drops rd_tag.

    assign live = allocated[res_rd_tag];
    assign peek = (state == ooo_pkg::PEEK_ONE) || (state == ooo_pkg::PEEK_REST);

    // Until PEEK_REST the dispatch hold word is the freshest copy.
    always_comb begin : operand_select
        if (state == ooo_pkg::PEEK_REST) begin
            have1      = src1_valid;
            have1_data = src1_data;
            have2      = src2_valid;
            have2_data = src2_data;
        end else begin
            have1      = res_src1_valid;
            have1_data = res_src1_data;
            have2      = res_src2_valid;
            have2_data = res_src2_data;
        end
        src1_rdy     = have1 | (peek & calculated[res_src1_tag]);
        src2_rdy     = have2 | (peek & calculated[res_src2_tag]);
        ex_src1_data = have1 ? have1_data : tag_data[res_src1_tag]; // Forward on start.
        ex_src2_data = have2 ? have2_data : tag_data[res_src2_tag];
    end

    assign res_empty = (state == ooo_pkg::EMPTY);
    assign start_exe = !res_empty && src1_rdy && src2_rdy && live;

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            ooo_pkg::EMPTY: begin
                if (load_word) begin
                    next_state = ooo_pkg::CHECK;
                end
            end
            default: begin
                if (!live || (src1_rdy && src2_rdy)) begin
                    next_state = ooo_pkg::EMPTY;
                end else if (state == ooo_pkg::CHECK) begin
                    next_state = ooo_pkg::PEEK_ONE;
                end else begin
                    next_state = ooo_pkg::PEEK_REST;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ooo_pkg::EMPTY;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (next_state == ooo_pkg::PEEK_REST) begin
            src1_valid <= src1_rdy; // Keep a value whose tag may retire.
            src1_data  <= ex_src1_data;
            src2_valid <= src2_rdy;
            src2_data  <= ex_src2_data;
        end
    end

    assign ex_op     = res_op;
    assign ex_funct7 = res_funct7;
    assign ex_rd_tag = res_rd_tag;
    assign ex_pc     = res_pc;
    assign ex_funct3 = (res_op == ooo_pkg::JAL || res_op == ooo_pkg::JALR) ? 3'b000 : res_funct3;

    assign jalr_executed = start_exe && (res_op == ooo_pkg::JALR);
    assign update_br     = start_exe && (res_op == ooo_pkg::BRANCH);
    assign ld_pc_to_cdb  = start_exe && (res_op != ooo_pkg::OP_REG) && (res_op != ooo_pkg::OP_IMM);

endmodule

`default_nettype wire

/* hdl/dispatch_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module dispatch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  ooo_pkg::op_e         issue_op,
    input  logic [2:0]           issue_funct3,
    input  logic [6:0]           issue_funct7,
    input  logic [`XLEN-1:0]     issue_pc,
    input  logic                 src1_valid,
    input  logic [`TAG_W-1:0]    src1_tag,
    input  logic [`XLEN-1:0]     src1_data,
    input  logic                 src2_valid,
    input  logic [`TAG_W-1:0]    src2_tag,
    input  logic [`XLEN-1:0]     src2_data,
    input  logic [`TAG_W-1:0]    alloc_tag,
    input  logic                 tags_full,
    input  logic [`NUM_RS-1:0]   rs_empty,
    input  logic [`NUM_TAGS-1:0] calculated,
    input  logic [`XLEN-1:0]     tag_data [`NUM_TAGS],
    output logic                 issue_stall,
    output logic                 alloc,
    output logic [`NUM_RS-1:0]   load_word,
    output ooo_pkg::op_e         rs_op [`NUM_RS],
    output logic [2:0]           rs_funct3 [`NUM_RS],
    output logic [6:0]           rs_funct7 [`NUM_RS],
    output logic [`XLEN-1:0]     rs_pc [`NUM_RS],
    output logic [`TAG_W-1:0]    rs_rd_tag [`NUM_RS],
    output logic [`NUM_RS-1:0]   rs_src1_valid,
    output logic [`TAG_W-1:0]    rs_src1_tag [`NUM_RS],
    output logic [`XLEN-1:0]     rs_src1_data [`NUM_RS],
    output logic [`NUM_RS-1:0]   rs_src2_valid,
    output logic [`TAG_W-1:0]    rs_src2_tag [`NUM_RS],
    output logic [`XLEN-1:0]     rs_src2_data [`NUM_RS]
);

    logic [`NUM_RS-1:0] pick;    // Lowest empty station, one-hot.
    logic [`NUM_RS-1:0] refresh; // Stations loaded on the last edge.

    assign pick        = rs_empty & (~rs_empty + 1'b1);
    assign issue_stall = ~(|rs_empty) | tags_full;
    assign alloc       = issue_valid & ~issue_stall;
    assign load_word   = alloc ? pick : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh <= '0;
        end else begin
            refresh <= load_word;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_RS; i++) begin
            if (load_word[i]) begin
                rs_op[i]         <= issue_op;
                rs_funct3[i]     <= issue_funct3;
                rs_funct7[i]     <= issue_funct7;
                rs_pc[i]         <= issue_pc;
                rs_rd_tag[i]     <= alloc_tag;
                rs_src1_valid[i] <= src1_valid;
                rs_src1_tag[i]   <= src1_tag;
                rs_src1_data[i]  <= src1_data;
                rs_src2_valid[i] <= src2_valid;
                rs_src2_tag[i]   <= src2_tag;
                rs_src2_data[i]  <= src2_data;
            end else if (refresh[i]) begin
                // Catches a producer that finished on the acceptance edge.
                if (!rs_src1_valid[i] && calculated[rs_src1_tag[i]]) begin
                    rs_src1_valid[i] <= 1'b1;
                    rs_src1_data[i]  <= tag_data[rs_src1_tag[i]];
                end
                if (!rs_src2_valid[i] && calculated[rs_src2_tag[i]]) begin
                    rs_src2_valid[i] <= 1'b1;
                    rs_src2_data[i]  <= tag_data[rs_src2_tag[i]];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rob_tracker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module rob_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    input  logic                 flush,
    input  logic [`NUM_RS-1:0]   wr_valid,
    input  logic [`TAG_W-1:0]    wr_tag [`NUM_RS],
    input  logic [`XLEN-1:0]     wr_data [`NUM_RS],
    input  logic [`NUM_RS-1:0]   wr_br,
    input  logic [`NUM_RS-1:0]   wr_jalr,
    input  logic [`XLEN-1:0]     wr_jalr_target [`NUM_RS],
    output logic [`TAG_W-1:0]    alloc_tag,
    output logic                 tags_full,
    output logic [`NUM_TAGS-1:0] allocated,
    output logic [`NUM_TAGS-1:0] calculated,
    output logic [`XLEN-1:0]     tag_data [`NUM_TAGS],
    output logic                 commit_valid,
    output logic [`TAG_W-1:0]    commit_tag,
    output logic [`XLEN-1:0]     commit_data,
    output logic                 commit_br,
    output logic                 jalr_valid,
    output logic [`XLEN-1:0]     jalr_target
);

    logic [`TAG_W-1:0]    head;  // Oldest allocated tag.
    logic [`TAG_W-1:0]    tail;  // Next tag to hand out.
    logic [`TAG_W:0]      count;
    logic [`NUM_TAGS-1:0] br_flag;
    logic [`NUM_TAGS-1:0] jalr_flag;
    logic [`XLEN-1:0]     jalr_word [`NUM_TAGS];

    assign alloc_tag    = tail;
    assign tags_full    = (count == `NUM_TAGS);
    assign commit_valid = allocated[head] & calculated[head]; // Retire in tag order.
    assign commit_tag   = head;
    assign commit_data  = tag_data[head];
    assign commit_br    = br_flag[head];
    assign jalr_valid   = commit_valid & jalr_flag[head];
    assign jalr_target  = jalr_word[head];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            allocated  <= '0;
            calculated <= '0;
        end else begin
            if (alloc) begin
                allocated[tail]  <= 1'b1;
                calculated[tail] <= 1'b0;
                tail             <= tail + 1'b1;
            end
            // A late write to a flushed tag must not mark it done.
            for (int i = 0; i < `NUM_RS; i++) begin
                if (wr_valid[i] && allocated[wr_tag[i]]) begin
                    calculated[wr_tag[i]] <= 1'b1;
                end
            end
            if (commit_valid) begin
                allocated[head] <= 1'b0; // Commit frees the tag.
                head            <= head + 1'b1;
            end
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_RS; i++) begin
            if (wr_valid[i]) begin
                tag_data[wr_tag[i]]  <= wr_data[i];
                br_flag[wr_tag[i]]   <= wr_br[i];
                jalr_flag[wr_tag[i]] <= wr_jalr[i];
                jalr_word[wr_tag[i]] <= wr_jalr_target[i];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    typedef enum logic [2:0] {
        OP_REG = 3'd0, // Register-register ALU.
        OP_IMM = 3'd1, // Immediate ALU, immediate arrives as source 2.
        BRANCH = 3'd2,
        JAL    = 3'd3,
        JALR   = 3'd4,
        AUIPC  = 3'd5,
        LUI    = 3'd6
    } op_e;

    typedef enum logic [1:0] {
        EMPTY     = 2'd0,
        CHECK     = 2'd1, // Word just loaded by dispatch.
        PEEK_ONE  = 2'd2, // Dispatch has refreshed the operands.
        PEEK_REST = 2'd3  // Waiting on calculated bits.
    } rs_state_e;

endpackage

`default_nettype wire

/* hdl/ooo_defines.svh */
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`define XLEN     32 // Data width.
`define NUM_TAGS 8  // Reorder tags.
`define TAG_W    3  // Tag index width.
`define NUM_RS   2  // Reservation stations, each with its own execution unit.

`endif
